//--- hw/srisc_pkg.sv
package srisc_pkg;

    localparam int default_data_width = 16;
    localparam int default_addr_width = 9;
    localparam int default_num_regs   = 8;

    typedef enum logic [3:0] {
        reset_st = 4'b0000,
        if1      = 4'b0001,
        if2      = 4'b0010,
        update   = 4'b0011,
        decode   = 4'b0100,
        s_a      = 4'b0101,
        s_b      = 4'b0110,
        s_c      = 4'b0111,
        s_d      = 4'b1000,
        s_e      = 4'b1001,
        s_f      = 4'b1010,
        s_g      = 4'b1011,
        halt     = 4'b1111
    } state_t;

    typedef enum logic [2:0] {
        op_ldr  = 3'b011,
        op_str  = 3'b100,
        op_alu  = 3'b101,
        op_move = 3'b110,
        op_halt = 3'b111
    } opcode_t;

    // also picks the move flavour with 10 for immediate and 00 for register
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        sh_none = 2'b00,
        sh_lsl  = 2'b01,
        sh_lsr  = 2'b10,
        sh_asr  = 2'b11
    } shift_t;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_read  = 2'b01,
        mem_write = 2'b11
    } mem_cmd_t;

    typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_t;

    typedef enum logic [1:0] {wb_c, wb_imm, wb_mdata} wb_sel_t;

endpackage

//--- hw/srisc_control.sv
`timescale 1ns/1ps

module srisc_control import srisc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  opcode_t  opcode,
    input  alu_op_t  op,
    output reg_sel_t nsel,
    output wb_sel_t  wb_sel,
    output logic     write,
    output logic     loada,
    output logic     loadb,
    output logic     loadc,
    output logic     loads,
    output logic     asel,
    output logic     bsel,
    output logic     load_ir,
    output logic     load_pc,
    output logic     load_addr,
    output logic     addr_sel,
    output mem_cmd_t mem_cmd
);

    localparam alu_op_t mov_imm_sel = alu_and;   // 10
    localparam alu_op_t mov_reg_sel = alu_add;   // 00

    state_t state;
    state_t next_state;
    logic   mov_imm;
    logic   mov_reg;
    logic   is_cmp;

    assign mov_imm = (opcode == op_move) && (op == mov_imm_sel);
    assign mov_reg = (opcode == op_move) && (op == mov_reg_sel);
    assign is_cmp  = (op == alu_cmp);

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= reset_st;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = halt;
        case (state)
            reset_st: next_state = if1;
            if1:      next_state = if2;
            if2:      next_state = update;
            update:   next_state = decode;
            decode:
            begin
                case (opcode)
                    op_move:                 next_state = (mov_imm || mov_reg) ? s_a : halt;
                    op_alu, op_ldr, op_str:  next_state = s_a;
                    default:                 next_state = halt;   // op_halt and unknown codes
                endcase
            end
            s_a:  next_state = mov_imm ? if1 : s_b;
            s_b:  next_state = s_c;
            s_c:  next_state = mov_reg ? if1 : s_d;
            s_d:  next_state = (opcode == op_alu) ? if1 : s_e;
            s_e:  next_state = (opcode == op_ldr) ? if1 : s_f;
            s_f:  next_state = if1;
            halt: next_state = halt;
            default: next_state = halt;
        endcase
    end

    always_comb
    begin
        nsel      = sel_rn;
        wb_sel    = wb_c;
        write     = 1'b0;
        loada     = 1'b0;
        loadb     = 1'b0;
        loadc     = 1'b0;
        loads     = 1'b0;
        asel      = 1'b0;
        bsel      = 1'b0;
        load_ir   = 1'b0;
        load_pc   = 1'b0;
        load_addr = 1'b0;
        addr_sel  = 1'b0;
        mem_cmd   = mem_none;
        case (state)
            if1:
            begin
                addr_sel = 1'b1;
                mem_cmd  = mem_read;
            end
            if2:
            begin
                addr_sel = 1'b1;
                mem_cmd  = mem_read;
                load_ir  = 1'b1;   // word from if1 read is on read_data now
            end
            update: load_pc = 1'b1;
            s_a:
            begin
                if (mov_imm)
                begin
                    wb_sel = wb_imm;
                    write  = 1'b1;
                end
                else if (mov_reg)
                begin
                    nsel  = sel_rm;
                    loadb = 1'b1;
                end
                else
                    loada = 1'b1;
            end
            s_b:
            begin
                if (mov_reg)
                begin
                    asel  = 1'b1;
                    loadc = 1'b1;
                end
                else if (opcode == op_alu)
                begin
                    nsel  = sel_rm;
                    loadb = 1'b1;
                end
                else
                begin
                    bsel  = 1'b1;   // address = Rn + sximm5
                    loadc = 1'b1;
                end
            end
            s_c:
            begin
                if (mov_reg)
                begin
                    nsel  = sel_rd;
                    write = 1'b1;
                end
                else if (opcode == op_alu)
                begin
                    loads = is_cmp;
                    loadc = !is_cmp;
                end
                else
                    load_addr = 1'b1;
            end
            s_d:
            begin
                if (opcode == op_alu)
                begin
                    nsel  = sel_rd;
                    write = !is_cmp;
                end
                else if (opcode == op_ldr)
                    mem_cmd = mem_read;
                else
                begin
                    nsel  = sel_rd;   // store data
                    loadb = 1'b1;
                end
            end
            s_e:
            begin
                if (opcode == op_ldr)
                begin
                    nsel   = sel_rd;
                    wb_sel = wb_mdata;
                    write  = 1'b1;
                end
                else
                begin
                    asel  = 1'b1;
                    loadc = 1'b1;
                end
            end
            s_f: mem_cmd = mem_write;
            default: ;
        endcase
    end

endmodule

//--- hw/pc_addr_unit.sv
`timescale 1ns/1ps

module pc_addr_unit import srisc_pkg::*;
#(
    parameter int addr_width = default_addr_width
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_pc,
    input  logic                  load_addr,
    input  logic                  addr_sel,
    input  logic [addr_width-1:0] c_addr,
    output logic [addr_width-1:0] mem_addr
);

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] data_addr;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (load_pc)
            pc <= pc + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            data_addr <= '0;
        else if (load_addr)
            data_addr <= c_addr;   // low bits of the computed address
    end

    assign mem_addr = addr_sel ? pc : data_addr;

endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import srisc_pkg::*;
#(
    parameter int data_width = default_data_width
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_ir,
    input  logic [data_width-1:0] read_data,
    output opcode_t               opcode,
    output alu_op_t               op,
    output logic [2:0]            rn,
    output logic [2:0]            rd,
    output logic [2:0]            rm,
    output shift_t                shift,
    output logic [data_width-1:0] sximm8,
    output logic [data_width-1:0] sximm5
);

    logic [data_width-1:0] ir;

    always_ff @(posedge clk)
    begin
        if (reset)
            ir <= '0;
        else if (load_ir)
            ir <= read_data;
    end

    assign opcode = opcode_t'(ir[15:13]);
    assign op     = alu_op_t'(ir[12:11]);
    assign rn     = ir[10:8];
    assign rd     = ir[7:5];
    assign rm     = ir[2:0];

    // loads and stores share bits 4:3 with imm5
    assign shift = (opcode == op_ldr || opcode == op_str) ? sh_none : shift_t'(ir[4:3]);

    assign sximm8 = {{(data_width-8){ir[7]}}, ir[7:0]};
    assign sximm5 = {{(data_width-5){ir[4]}}, ir[4:0]};

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import srisc_pkg::*;
#(
    parameter int data_width = default_data_width,
    parameter int num_regs   = default_num_regs
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  write,
    input  reg_sel_t              nsel,
    input  wb_sel_t               wb_sel,
    input  logic [2:0]            rn,
    input  logic [2:0]            rd,
    input  logic [2:0]            rm,
    input  logic [data_width-1:0] c,
    input  logic [data_width-1:0] sximm8,
    input  logic [data_width-1:0] mdata,
    output logic [data_width-1:0] read_value
);

    logic [data_width-1:0] regs [num_regs];
    logic [2:0]            idx;
    logic [data_width-1:0] wb_value;

    // one index serves both the read and the write port
    always_comb
    begin
        case (nsel)
            sel_rd:  idx = rd;
            sel_rm:  idx = rm;
            default: idx = rn;
        endcase
    end

    always_comb
    begin
        case (wb_sel)
            wb_imm:   wb_value = sximm8;
            wb_mdata: wb_value = mdata;
            default:  wb_value = c;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end
        else if (write)
            regs[idx] <= wb_value;
    end

    assign read_value = regs[idx];

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import srisc_pkg::*;
#(
    parameter int data_width = default_data_width
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  loada,
    input  logic                  loadb,
    input  logic                  loadc,
    input  logic                  loads,
    input  logic                  asel,
    input  logic                  bsel,
    input  alu_op_t               op,
    input  shift_t                shift,
    input  logic [data_width-1:0] read_value,
    input  logic [data_width-1:0] sximm5,
    output logic [data_width-1:0] c,
    output logic                  n,
    output logic                  v,
    output logic                  z
);

    logic [data_width-1:0] a_reg;
    logic [data_width-1:0] b_reg;
    logic [data_width-1:0] b_shifted;
    logic [data_width-1:0] ain;
    logic [data_width-1:0] bin;
    logic [data_width-1:0] result;
    logic [data_width-1:0] diff;
    logic                  sub_ovf;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            a_reg <= '0;
            b_reg <= '0;
        end
        else
        begin
            if (loada)
                a_reg <= read_value;
            if (loadb)
                b_reg <= read_value;
        end
    end

    always_comb
    begin
        case (shift)
            sh_lsl:  b_shifted = b_reg << 1;
            sh_lsr:  b_shifted = b_reg >> 1;
            sh_asr:  b_shifted = {b_reg[data_width-1], b_reg[data_width-1:1]};
            default: b_shifted = b_reg;
        endcase
    end

    assign ain = asel ? '0 : a_reg;
    assign bin = bsel ? sximm5 : b_shifted;

    assign diff    = ain - bin;
    // operands differ in sign and the result sign flips away from a
    assign sub_ovf = (ain[data_width-1] != bin[data_width-1]) &&
                     (diff[data_width-1] != ain[data_width-1]);

    always_comb
    begin
        case (op)
            alu_cmp: result = diff;
            alu_and: result = ain & bin;
            alu_mvn: result = ~bin;
            default: result = ain + bin;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            c <= '0;
            n <= 1'b0;
            v <= 1'b0;
            z <= 1'b0;
        end
        else
        begin
            if (loadc)
                c <= result;
            if (loads)
            begin
                n <= result[data_width-1];
                v <= sub_ovf;
                z <= (result == '0);
            end
        end
    end

endmodule

//--- hw/srisc_cpu.sv
`timescale 1ns/1ps

module srisc_cpu import srisc_pkg::*;
#(
    parameter int data_width = default_data_width,
    parameter int addr_width = default_addr_width,
    parameter int num_regs   = default_num_regs
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [data_width-1:0] read_data,
    output logic [data_width-1:0] out,
    output logic                  n,
    output logic                  v,
    output logic                  z,
    output logic [addr_width-1:0] mem_addr,
    output mem_cmd_t              mem_cmd
);

    opcode_t               opcode;
    alu_op_t               op;
    shift_t                shift;
    logic [2:0]            rn;
    logic [2:0]            rd;
    logic [2:0]            rm;
    logic [data_width-1:0] sximm8;
    logic [data_width-1:0] sximm5;
    logic [data_width-1:0] read_value;
    reg_sel_t              nsel;
    wb_sel_t               wb_sel;
    logic                  write;
    logic                  loada;
    logic                  loadb;
    logic                  loadc;
    logic                  loads;
    logic                  asel;
    logic                  bsel;
    logic                  load_ir;
    logic                  load_pc;
    logic                  load_addr;
    logic                  addr_sel;

    srisc_control i_control (
        .clk(clk), .reset(reset), .opcode(opcode), .op(op),
        .nsel(nsel), .wb_sel(wb_sel), .write(write),
        .loada(loada), .loadb(loadb), .loadc(loadc), .loads(loads),
        .asel(asel), .bsel(bsel), .load_ir(load_ir), .load_pc(load_pc),
        .load_addr(load_addr), .addr_sel(addr_sel), .mem_cmd(mem_cmd)
    );

    pc_addr_unit #(.addr_width(addr_width)) i_pc_addr (
        .clk(clk), .reset(reset), .load_pc(load_pc), .load_addr(load_addr),
        .addr_sel(addr_sel), .c_addr(out[addr_width-1:0]), .mem_addr(mem_addr)
    );

    instr_decode #(.data_width(data_width)) i_decode (
        .clk(clk), .reset(reset), .load_ir(load_ir), .read_data(read_data),
        .opcode(opcode), .op(op), .rn(rn), .rd(rd), .rm(rm), .shift(shift),
        .sximm8(sximm8), .sximm5(sximm5)
    );

    reg_file #(.data_width(data_width), .num_regs(num_regs)) i_regs (
        .clk(clk), .reset(reset), .write(write), .nsel(nsel), .wb_sel(wb_sel),
        .rn(rn), .rd(rd), .rm(rm), .c(out), .sximm8(sximm8),
        .mdata(read_data), .read_value(read_value)
    );

    execute_unit #(.data_width(data_width)) i_execute (
        .clk(clk), .reset(reset), .loada(loada), .loadb(loadb), .loadc(loadc),
        .loads(loads), .asel(asel), .bsel(bsel), .op(op), .shift(shift),
        .read_value(read_value), .sximm5(sximm5), .c(out), .n(n), .v(v), .z(z)
    );

endmodule

//--- testbench/srisc_cpu_props.sv
`timescale 1ns/1ps

module srisc_cpu_props import srisc_pkg::*;
#(
    parameter int addr_width = default_addr_width
)
(
    input logic                  clk,
    input logic                  reset,
    input mem_cmd_t              mem_cmd,
    input logic [addr_width-1:0] mem_addr,
    input logic                  addr_sel,
    input logic                  load_ir,
    input logic                  write,
    input opcode_t               opcode
);

    logic [addr_width-1:0] last_fetch;
    logic                  fetched;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            last_fetch <= '0;
            fetched    <= 1'b0;
        end
        else if (load_ir)
        begin
            last_fetch <= mem_addr;   // address of the instruction word just read
            fetched    <= 1'b1;
        end
    end

    reset_idle: assert property (@(posedge clk) reset |=> mem_cmd == mem_none)
        else $error("memory command not idle after reset");

    first_fetch: assert property (@(posedge clk)
        $fell(reset) |=> mem_cmd == mem_read && mem_addr == '0)
        else $error("first fetch does not read address 0");

    fetch_read: assert property (@(posedge clk) disable iff (reset)
        load_ir |-> addr_sel && mem_cmd == mem_read)
        else $error("instruction register loads outside a fetch read");

    // no branches, so fetches walk through memory one word at a time
    fetch_step: assert property (@(posedge clk) disable iff (reset)
        load_ir && fetched |-> mem_addr == addr_width'(last_fetch + 1))
        else $error("fetch address is not the previous fetch address plus one");

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        opcode == op_halt |-> mem_cmd == mem_none && !write)
        else $error("memory or register activity after HALT");

    halt_stays: assert property (@(posedge clk) disable iff (reset)
        opcode == op_halt |=> opcode == op_halt)
        else $error("CPU left HALT");

endmodule

//--- testbench/tb_srisc_cpu.sv
`timescale 1ns/1ps

module tb_srisc_cpu import srisc_pkg::*;
();

    localparam int mem_words = 512;

    logic        clk;
    logic        reset;
    logic [15:0] read_data;
    logic [15:0] out;
    logic        n;
    logic        v;
    logic        z;
    logic [8:0]  mem_addr;
    mem_cmd_t    mem_cmd;

    logic [15:0] mem [mem_words];
    logic [15:0] ref_mem [mem_words];
    logic [15:0] ref_regs [8];
    logic        ref_n;
    logic        ref_v;
    logic        ref_z;
    logic [8:0]  exp_addr [$];
    logic [15:0] exp_data [$];
    logic [2:0]  exp_flags [$];
    logic [31:0] lfsr;
    logic [15:0] rd_word;
    logic        program_ready;
    int          pc_words;
    int          total_cycles;
    int          store_count;
    int          errors;

    srisc_cpu i_dut (
        .clk(clk), .reset(reset), .read_data(read_data), .out(out),
        .n(n), .v(v), .z(z), .mem_addr(mem_addr), .mem_cmd(mem_cmd)
    );

    bind srisc_cpu srisc_cpu_props #(.addr_width(addr_width)) i_props (
        .clk(clk), .reset(reset), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
        .addr_sel(addr_sel), .load_ir(load_ir), .write(write), .opcode(opcode)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++)
            b[i] = lfsr_bit();
        return b;
    endfunction

    function automatic logic [15:0] fill_word(int a);
        return 16'(a * 40717) ^ 16'h5a3c;   // odd multiplier keeps every address distinct
    endfunction

    function automatic logic [15:0] shifted(logic [15:0] val, shift_t sh);
        case (sh)
            sh_lsl:  return val << 1;
            sh_lsr:  return val >> 1;
            sh_asr:  return {val[15], val[15:1]};
            default: return val;
        endcase
    endfunction

    // places one instruction and steps the reference model over it
    task automatic assemble(opcode_t opc, logic [1:0] op, logic [2:0] rn, logic [7:0] low);
        logic [2:0]  rd;
        logic [2:0]  rm;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm5;
        logic [15:0] sum;
        logic [15:0] diff;
        int          sdiff;
        rd   = low[7:5];
        rm   = low[2:0];
        imm5 = {{11{low[4]}}, low[4:0]};
        a    = ref_regs[rn];
        b    = shifted(ref_regs[rm], shift_t'(low[4:3]));
        sum  = a + imm5;
        mem[pc_words]     = {opc, op, rn, low};
        ref_mem[pc_words] = {opc, op, rn, low};
        pc_words++;
        case (opc)
            op_move:
            begin
                if (op == 2'b10)
                begin
                    ref_regs[rn] = {{8{low[7]}}, low};
                    total_cycles += 5;
                end
                else
                begin
                    ref_regs[rd] = b;   // left operand is zero
                    total_cycles += 7;
                end
            end
            op_alu:
            begin
                case (alu_op_t'(op))
                    alu_add: ref_regs[rd] = a + b;
                    alu_and: ref_regs[rd] = a & b;
                    alu_mvn: ref_regs[rd] = ~b;
                    default:
                    begin
                        diff  = a - b;
                        sdiff = int'($signed(a)) - int'($signed(b));
                        ref_n = diff[15];
                        ref_z = (diff == 16'h0000);
                        ref_v = (sdiff > 32767) || (sdiff < -32768);
                    end
                endcase
                total_cycles += 8;
            end
            op_ldr:
            begin
                ref_regs[rd] = ref_mem[sum[8:0]];
                total_cycles += 9;
            end
            op_str:
            begin
                ref_mem[sum[8:0]] = ref_regs[rd];
                exp_addr.push_back(sum[8:0]);
                exp_data.push_back(ref_regs[rd]);
                exp_flags.push_back({ref_n, ref_v, ref_z});
                total_cycles += 10;
            end
            default: ;
        endcase
    endtask

    task automatic build_program();
        assemble(op_move, 2'b10, 3'd0, random_byte());
        assemble(op_move, 2'b10, 3'd1, random_byte());
        assemble(op_move, 2'b10, 3'd7, 8'd64);              // store base
        assemble(op_str, 2'b00, 3'd7, {3'd0, 5'd0});
        for (int s = 0; s < 4; s++)                          // R2..R5 from R1, one per shift
            assemble(op_move, 2'b00, 3'd0, {3'(s + 2), 2'(s), 3'd1});
        for (int s = 0; s < 4; s++)
            assemble(op_str, 2'b00, 3'd7, {3'(s + 2), 5'(s + 1)});
        assemble(op_alu, alu_add, 3'd0, {3'd2, sh_lsl, 3'd1});
        assemble(op_alu, alu_and, 3'd0, {3'd3, sh_asr, 3'd1});
        assemble(op_alu, alu_mvn, 3'd0, {3'd4, sh_lsr, 3'd0});
        for (int s = 0; s < 3; s++)
            assemble(op_str, 2'b00, 3'd7, {3'(s + 2), 5'(s + 5)});
        assemble(op_alu, alu_cmp, 3'd0, {3'd0, sh_none, 3'd1});
        assemble(op_str, 2'b00, 3'd7, {3'd0, 5'd8});
        assemble(op_ldr, 2'b00, 3'd7, {3'd6, 5'd8});
        assemble(op_str, 2'b00, 3'd7, {3'd6, 5'b10000});    // offset -16
        assemble(op_halt, 2'b00, 3'd0, 8'd0);
    endtask

    task automatic check_store();
        if (store_count >= exp_addr.size())
        begin
            errors++;
            $display("unexpected memory write to address %0h at %0t", mem_addr, $time);
        end
        else
        begin
            assert (mem_addr == exp_addr[store_count] && out == exp_data[store_count]
                    && {n, v, z} == exp_flags[store_count])
            else
            begin
                errors++;
                $display("Error at %0t: store %0d wrote %h to %h nvz %b", $time,
                         store_count, out, mem_addr, {n, v, z});
                $display("Error at %0t: expected %h to %h nvz %b", $time,
                         exp_data[store_count], exp_addr[store_count], exp_flags[store_count]);
            end
        end
        store_count++;
    endtask

    // synchronous memory with read data one cycle after the request
    always @(posedge clk)
    begin
        if (mem_cmd == mem_read)
            rd_word = mem[mem_addr];
        if (mem_cmd == mem_write)
        begin
            check_store();
            mem[mem_addr] = out;
        end
        #5;
        read_data = rd_word;
    end

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        reset         = 1'b1;
        read_data     = '0;
        rd_word       = '0;
        lfsr          = 32'h8cb4_2074;
        program_ready = 1'b0;
        pc_words      = 0;
        total_cycles  = 0;
        store_count   = 0;
        errors        = 0;
        ref_n         = 1'b0;
        ref_v         = 1'b0;
        ref_z         = 1'b0;
        for (int i = 0; i < 8; i++)
            ref_regs[i] = '0;
        for (int i = 0; i < mem_words; i++)
        begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        build_program();
        program_ready = 1'b1;
        repeat (4) @(posedge clk);
        #5 reset = 1'b0;
        while (i_dut.i_control.state != halt)
            @(posedge clk);
        repeat (10) @(posedge clk);   // halted CPU must stay quiet
        if (store_count < exp_addr.size())
        begin
            errors++;
            $display("only %0d of %0d memory writes were seen", store_count, exp_addr.size());
        end
        assert ({n, v, z} == {ref_n, ref_v, ref_z})
        else
        begin
            errors++;
            $display("Error at %0t: final nvz %b, expected %b", $time, {n, v, z},
                     {ref_n, ref_v, ref_z});
        end
        $display("errors: %0d, stores checked: %0d", errors, store_count);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        wait (program_ready);
        repeat (20 * total_cycles) @(posedge clk);
        $display("timeout: the CPU did not reach HALT within %0d cycles", 20 * total_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

//--- srisc_cpu.f
hw/srisc_pkg.sv
hw/srisc_control.sv
hw/pc_addr_unit.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/srisc_cpu.sv
testbench/srisc_cpu_props.sv
testbench/tb_srisc_cpu.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_srisc_cpu
FILELIST = srisc_cpu.f
LOG      = sim.log

.PHONY: sim clean

# a run stopped by a failing assertion never prints the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
